// ==== source/muldiv_settings.svh ====
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// operand and result word width
// both units and the result bus use it
`define MULDIV_WIDTH 32

// width of one partial product operand
// always half a word
`define MULDIV_HALF 16

// divider iteration counter width
// counts 31 down to -1 so the msb acts as a sign bit
// one bit wider than a bit index into the word
`define MULDIV_CNT_W 6

`endif

// ==== source/muldiv_pkg.sv ====
`include "muldiv_settings.svh"

// types shared by the multiply/divide unit
package muldiv_pkg;

	// one data word
	typedef logic [`MULDIV_WIDTH-1:0] word_t;

	// which unit put the word on the result bus
	typedef enum logic
	{
		SRC_MUL = 1'b0,
		SRC_DIV = 1'b1
	} res_src_t;

endpackage

// ==== source/mul_unit.sv ====
`include "muldiv_settings.svh"

// low word of a full-width product
// built from three half-width partial products
// the high x high term only lands above the low word so it is never formed
module mul_unit
	import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input word_t x,
	input word_t y,
	input logic grant,
	output logic idle,
	output logic done,
	output word_t prod
);

	// operand latches
	word_t x_q;
	word_t y_q;

	// low x low and the two cross terms
	word_t pp_ll;
	word_t pp_lh;
	word_t pp_hl;

	// cross terms added before the shift
	word_t cross_sum;

	logic busy;
	// low while the partial products are pending
	logic phase;
	logic accept;
	logic pp_en;
	logic sum_en;

	// start only counts while idle
	assign accept = start && !busy;
	assign idle = !busy;

	// stage strobes, nothing moves once done is up
	assign pp_en = busy && !done && !phase;
	assign sum_en = busy && !done && phase;

	assign cross_sum = pp_lh + pp_hl;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			phase <= 1'b0;
			done <= 1'b0;
		end
		else if (accept)
		begin
			busy <= 1'b1;
			phase <= 1'b0;
		end
		else if (grant)
		begin
			// result taken by the arbiter
			busy <= 1'b0;
			done <= 1'b0;
		end
		else if (pp_en)
		begin
			phase <= 1'b1;
		end
		else if (sum_en)
		begin
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			x_q <= x;
			y_q <= y;
		end
		// first stage, three multiplies in parallel
		if (pp_en)
		begin
			pp_ll <= x_q[`MULDIV_HALF-1:0] * y_q[`MULDIV_HALF-1:0];
			pp_lh <= x_q[`MULDIV_HALF-1:0] * y_q[`MULDIV_WIDTH-1:`MULDIV_HALF];
			pp_hl <= x_q[`MULDIV_WIDTH-1:`MULDIV_HALF] * y_q[`MULDIV_HALF-1:0];
		end
		// second stage
		// cross terms move up by half a word, their top half falls off
		if (sum_en)
		begin
			prod <= pp_ll + (cross_sum << `MULDIV_HALF);
		end
	end

	// the arbiter only grants a unit that holds a finished product
	assert property (@(posedge clk) disable iff (rst) grant |-> done);

endmodule

// ==== source/div_unit.sv ====
`include "muldiv_settings.svh"

// non-restoring divider, one quotient digit per cycle
// signed mode works on magnitudes and fixes the signs at the end
// quotient truncates toward zero, remainder follows the numerator sign
// division by zero is undefined
module div_unit
	import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic is_signed,
	input word_t num,
	input word_t denom,
	input logic grant,
	output logic idle,
	output logic done,
	output word_t quot,
	output word_t rem
);

	// phase encodings after the load edge
	localparam logic [1:0] PH_NEG = 2'd0;
	// first iteration edge only loads the working value
	localparam logic [1:0] PH_SETUP = 2'd1;
	localparam logic [1:0] PH_ITER = 2'd2;
	localparam logic [1:0] PH_FIX = 2'd3;

	logic busy;
	logic [1:0] phase;
	// digit index, ends at -1
	logic [`MULDIV_CNT_W-1:0] cnt;

	// operands, turned into magnitudes in place
	word_t num_q;
	word_t den_q;
	logic sgn_q;
	logic num_neg;
	logic den_neg;

	// partial remainder, double width plus a sign bit
	logic [2*`MULDIV_WIDTH:0] p_rem;
	logic [2*`MULDIV_WIDTH:0] p_shift;
	logic [2*`MULDIV_WIDTH:0] p_next;
	// divisor aligned with the upper half of the partial remainder
	logic [2*`MULDIV_WIDTH:0] d_ext;
	logic p_neg;

	// one bit per step
	// set for a +1 digit, clear for a -1 digit
	word_t q_dig;
	word_t q_bin;
	word_t r_mag;

	logic accept;
	logic neg_en;
	logic setup_en;
	logic iter_en;
	logic fix_en;

	assign accept = start && !busy;
	assign idle = !busy;

	assign neg_en = busy && !done && (phase == PH_NEG);
	assign setup_en = busy && !done && (phase == PH_SETUP);
	assign iter_en = busy && !done && (phase == PH_ITER);
	assign fix_en = busy && !done && (phase == PH_FIX);

	assign p_neg = p_rem[2*`MULDIV_WIDTH];
	assign d_ext = {1'b0, den_q, {`MULDIV_WIDTH{1'b0}}};
	assign p_shift = {p_rem[2*`MULDIV_WIDTH-1:0], 1'b0};

	// subtract on a positive remainder, add back on a negative one
	assign p_next = p_neg ? (p_shift + d_ext) : (p_shift - d_ext);

	// digit word to binary, one less if the last remainder went negative
	assign q_bin = q_dig - ~q_dig - word_t'(p_neg);

	// low half of the remainder is zero here
	// so the divisor adds straight onto the upper half
	assign r_mag = p_neg
		? (p_rem[2*`MULDIV_WIDTH-1:`MULDIV_WIDTH] + den_q)
		: p_rem[2*`MULDIV_WIDTH-1:`MULDIV_WIDTH];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			phase <= PH_NEG;
			cnt <= '1;
		end
		else if (accept)
		begin
			busy <= 1'b1;
			phase <= PH_NEG;
		end
		else if (grant)
		begin
			busy <= 1'b0;
			done <= 1'b0;
		end
		else if (neg_en)
		begin
			phase <= PH_SETUP;
		end
		else if (setup_en)
		begin
			cnt <= `MULDIV_CNT_W'(`MULDIV_WIDTH - 1);
			phase <= PH_ITER;
		end
		else if (iter_en)
		begin
			cnt <= cnt - 1'b1;
			// digit 0 is the last step
			if (cnt == '0)
			begin
				phase <= PH_FIX;
			end
		end
		else if (fix_en)
		begin
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		// load edge records the signs before the negation
		if (accept)
		begin
			num_q <= num;
			den_q <= denom;
			sgn_q <= is_signed;
			num_neg <= num[`MULDIV_WIDTH-1];
			den_neg <= denom[`MULDIV_WIDTH-1];
		end
		if (neg_en)
		begin
			if (sgn_q && num_neg)
			begin
				num_q <= -num_q;
			end
			if (sgn_q && den_neg)
			begin
				den_q <= -den_q;
			end
		end
		if (setup_en)
		begin
			p_rem <= {{(`MULDIV_WIDTH + 1){1'b0}}, num_q};
		end
		if (iter_en)
		begin
			p_rem <= p_next;
			q_dig[cnt[`MULDIV_CNT_W-2:0]] <= !p_neg;
		end
		// correction and sign fix-up
		if (fix_en)
		begin
			quot <= (sgn_q && (num_neg ^ den_neg)) ? -q_bin : q_bin;
			rem <= (sgn_q && num_neg) ? -r_mag : r_mag;
		end
	end

	// counter never leaves 31 down to -1 during an operation
	assert property (@(posedge clk) disable iff (rst)
		busy |-> ($signed(cnt) >= -1) && ($signed(cnt) <= `MULDIV_WIDTH - 1));

endmodule

// ==== source/result_arbiter.sv ====
`include "muldiv_settings.svh"

// shares one registered result bus between the two units
// grants come straight from the done levels
// a tie goes to the unit that was not served last
module result_arbiter
	import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic mul_done,
	input word_t mul_prod,
	input logic div_done,
	input word_t div_quot,
	input word_t div_rem,
	output logic mul_grant,
	output logic div_grant,
	output word_t result,
	output word_t result_rem,
	output res_src_t result_src,
	output logic result_valid
);

	// high when the divider got the last grant
	logic last_div;

	// divider wins alone or on a tie after a multiply
	assign div_grant = div_done && (!mul_done || !last_div);
	assign mul_grant = mul_done && (!div_done || last_div);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result_valid <= 1'b0;
			last_div <= 1'b0;
		end
		else
		begin
			// one pulse per granted result
			result_valid <= mul_grant || div_grant;
			if (mul_grant)
			begin
				last_div <= 1'b0;
			end
			else if (div_grant)
			begin
				last_div <= 1'b1;
			end
		end
	end

	// bus holds its last value between pulses
	always_ff @(posedge clk)
	begin
		if (mul_grant)
		begin
			result <= mul_prod;
			// no remainder for a product
			result_rem <= '0;
			result_src <= SRC_MUL;
		end
		else if (div_grant)
		begin
			result <= div_quot;
			result_rem <= div_rem;
			result_src <= SRC_DIV;
		end
	end

	// a served unit drops done so it never wins two cycles in a row
	assert property (@(posedge clk) disable iff (rst) mul_grant |=> !mul_grant);
	assert property (@(posedge clk) disable iff (rst) div_grant |=> !div_grant);

endmodule

// ==== source/muldiv_top.sv ====
`include "muldiv_settings.svh"

// multiplier and divider side by side
// both read the same operands and share the result bus
module muldiv_top
	import muldiv_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic mul_start,
	input logic div_start,
	input logic div_signed,
	input word_t a,
	input word_t b,
	output logic mul_idle,
	output logic div_idle,
	output word_t result,
	output word_t result_rem,
	output res_src_t result_src,
	output logic result_valid
);

	// multiplier to arbiter
	logic mul_done;
	logic mul_grant;
	word_t mul_prod;

	// divider to arbiter
	logic div_done;
	logic div_grant;
	word_t div_quot;
	word_t div_rem;

	mul_unit u_mul
	(
		.clk(clk),
		.rst(rst),
		.start(mul_start),
		.x(a),
		.y(b),
		.grant(mul_grant),
		.idle(mul_idle),
		.done(mul_done),
		.prod(mul_prod)
	);

	// a is the numerator, b the denominator
	div_unit u_div
	(
		.clk(clk),
		.rst(rst),
		.start(div_start),
		.is_signed(div_signed),
		.num(a),
		.denom(b),
		.grant(div_grant),
		.idle(div_idle),
		.done(div_done),
		.quot(div_quot),
		.rem(div_rem)
	);

	result_arbiter u_arb
	(
		.clk(clk),
		.rst(rst),
		.mul_done(mul_done),
		.mul_prod(mul_prod),
		.div_done(div_done),
		.div_quot(div_quot),
		.div_rem(div_rem),
		.mul_grant(mul_grant),
		.div_grant(div_grant),
		.result(result),
		.result_rem(result_rem),
		.result_src(result_src),
		.result_valid(result_valid)
	);

endmodule

// ==== testbench/tb_muldiv_vectors.svh ====
`ifndef TB_MULDIV_VECTORS_SVH
`define TB_MULDIV_VECTORS_SVH

// operation of a table row
localparam int OP_MUL = 0;
localparam int OP_UDIV = 1;
localparam int OP_SDIV = 2;
localparam int NUM_ROWS = 40;

// columns: op, a, b, expected product or quotient, expected remainder,
// start next row too, cycles between the two starts
int op_tab [NUM_ROWS];
word_t a_tab [NUM_ROWS];
word_t b_tab [NUM_ROWS];
word_t q_tab [NUM_ROWS];
word_t r_tab [NUM_ROWS];
logic pair_tab [NUM_ROWS];
int lag_tab [NUM_ROWS];

// xorshift32 step
function automatic word_t xorshift32(input word_t s);
	word_t x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

task automatic set_row(input int i, input int op, input word_t x, input word_t y,
	input word_t q, input word_t r, input logic pair, input int lag);
	op_tab[i] = op;
	a_tab[i] = x;
	b_tab[i] = y;
	q_tab[i] = q;
	r_tab[i] = r;
	pair_tab[i] = pair;
	lag_tab[i] = lag;
endtask

// directed rows 0 to 17
task automatic load_directed();
	// all ones, then halves whose cross terms carry
	set_row(0, OP_MUL, 32'hffffffff, 32'hffffffff, 32'h00000001, 32'h0, 0, 0);
	set_row(1, OP_MUL, 32'h0000ffff, 32'h0000ffff, 32'hfffe0001, 32'h0, 0, 0);
	set_row(2, OP_MUL, 32'h0001ffff, 32'h00010001, 32'h0000ffff, 32'h0, 0, 0);
	set_row(3, OP_MUL, 32'h0000ffff, 32'h00010001, 32'hffffffff, 32'h0, 0, 0);
	set_row(4, OP_MUL, 32'h80000000, 32'h00000002, 32'h00000000, 32'h0, 0, 0);
	set_row(5, OP_MUL, 32'h00010000, 32'h00010000, 32'h00000000, 32'h0, 0, 0);
	// row 7 has a divisor above the numerator
	set_row(6, OP_UDIV, 32'h00000064, 32'h00000007, 32'h0000000e, 32'h00000002, 0, 0);
	set_row(7, OP_UDIV, 32'h00000005, 32'h00000009, 32'h00000000, 32'h00000005, 0, 0);
	set_row(8, OP_UDIV, 32'hffffffff, 32'h00000001, 32'hffffffff, 32'h00000000, 0, 0);
	set_row(9, OP_UDIV, 32'hffffffff, 32'h10000000, 32'h0000000f, 32'h0fffffff, 0, 0);
	set_row(10, OP_UDIV, 32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000, 0, 0);
	// all four sign pairs of 7 and 2
	set_row(11, OP_SDIV, 32'h00000007, 32'h00000002, 32'h00000003, 32'h00000001, 0, 0);
	set_row(12, OP_SDIV, 32'hfffffff9, 32'h00000002, 32'hfffffffd, 32'hffffffff, 0, 0);
	set_row(13, OP_SDIV, 32'h00000007, 32'hfffffffe, 32'hfffffffd, 32'h00000001, 0, 0);
	set_row(14, OP_SDIV, 32'hfffffff9, 32'hfffffffe, 32'h00000003, 32'hffffffff, 0, 0);
	set_row(15, OP_SDIV, 32'h80000000, 32'h00000002, 32'hc0000000, 32'h00000000, 0, 0);
	// both units started on one edge, so the operands match
	set_row(16, OP_MUL, 32'hffffff9c, 32'h00000007, 32'hfffffd44, 32'h0, 1, 0);
	set_row(17, OP_SDIV, 32'hffffff9c, 32'h00000007, 32'hfffffff2, 32'hfffffffe, 0, 0);
endtask

`endif

// ==== testbench/tb_muldiv.sv ====
`include "muldiv_settings.svh"

// testbench for the multiply/divide top level
module tb_muldiv
	import muldiv_pkg::*;
();

	localparam int W = `MULDIV_WIDTH;

	logic clk;
	logic rst;
	logic mul_start;
	logic div_start;
	logic div_signed;
	word_t a;
	word_t b;
	logic mul_idle;
	logic div_idle;
	word_t result;
	word_t result_rem;
	res_src_t result_src;
	logic result_valid;

	`include "tb_muldiv_vectors.svh"

	// pulses seen on the bus, remainder in the upper word
	logic [2*W-1:0] mul_got [$];
	logic [2*W-1:0] div_got [$];
	int pass_cnt = 0;
	int fail_cnt = 0;
	word_t rng = 32'ha9c89603;

	muldiv_top dut0
	(
		.clk(clk),
		.rst(rst),
		.mul_start(mul_start),
		.div_start(div_start),
		.div_signed(div_signed),
		.a(a),
		.b(b),
		.mul_idle(mul_idle),
		.div_idle(div_idle),
		.result(result),
		.result_rem(result_rem),
		.result_src(result_src),
		.result_valid(result_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// whole run bounded by the table length
	initial
	begin
		#(NUM_ROWS * 60 * 20);
		$display("watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	// bus sampled on the edge, values from the cycle before
	always @(posedge clk)
	begin
		if (!rst && result_valid === 1'b1)
		begin
			if (result_src == SRC_MUL)
				mul_got.push_back({result_rem, result});
			else
				div_got.push_back({result_rem, result});
		end
	end

	// expected word from the rules of each operation
	// signed: magnitudes, quotient toward zero, remainder keeps numerator sign
	function automatic logic [2*W-1:0] expect_of(input int op, input word_t x, input word_t y);
		word_t mx;
		word_t my;
		word_t q;
		word_t r;
		if (op == OP_MUL)
			return {word_t'(0), word_t'(x * y)};
		mx = (op == OP_SDIV && x[W-1]) ? -x : x;
		my = (op == OP_SDIV && y[W-1]) ? -y : y;
		q = mx / my;
		r = mx % my;
		if (op == OP_SDIV && (x[W-1] ^ y[W-1]))
			q = -q;
		if (op == OP_SDIV && x[W-1])
			r = -r;
		return {r, q};
	endfunction

	// rows 18 to 29 are divide then multiply pairs swept across the tie point
	// rows 30 to 39 are single random operations
	task automatic fill_random();
		int op;
		word_t x;
		word_t y;
		logic [2*W-1:0] e;
		for (int i = 18; i < NUM_ROWS; i++)
		begin
			if (i < 30)
				op = (i % 2 == 1) ? OP_MUL : ((i % 4 == 2) ? OP_UDIV : OP_SDIV);
			else
				op = i % 3;
			rng = xorshift32(rng);
			x = rng;
			rng = xorshift32(rng);
			y = rng;
			// shorter divisors give longer quotients
			if (op == OP_UDIV)
				y = y >> rng[4:0];
			if (y == '0)
				y = 1;
			if (op == OP_SDIV && x == (word_t'(1) << (W - 1)) && y == '1)
				y = 2;
			e = expect_of(op, x, y);
			set_row(i, op, x, y, e[W-1:0], e[2*W-1:W], i < 30 && i % 2 == 0, 31 + (i - 18) / 2);
		end
	endtask

	task automatic drive_row(input int i);
		a = a_tab[i];
		b = b_tab[i];
		if (op_tab[i] == OP_MUL)
			mul_start = 1'b1;
		else
		begin
			div_start = 1'b1;
			div_signed = (op_tab[i] == OP_SDIV);
		end
	endtask

	task automatic wait_idle(input int i);
		while (!(op_tab[i] == OP_MUL ? mul_idle : div_idle))
			@(negedge clk);
	endtask

	// up to n pulses, then a few cycles more so that extra ones show up
	task automatic collect_results(input int n);
		int waited;
		waited = 0;
		while (mul_got.size() + div_got.size() < n && waited < 100)
		begin
			@(negedge clk);
			waited++;
		end
		repeat (3) @(negedge clk);
	endtask

	task automatic tally(input string name, input logic ok);
		if (ok)
			pass_cnt++;
		else
			fail_cnt++;
		$display("%s: %s", name, ok ? "ok" : "FAIL");
	endtask

	task automatic check_row(input int i);
		logic [2*W-1:0] got;
		logic ok;
		ok = 1'b1;
		if ((op_tab[i] == OP_MUL ? mul_got.size() : div_got.size()) == 0)
		begin
			$display("row %0d never got a result pulse from its unit", i);
			ok = 1'b0;
		end
		else
		begin
			if (op_tab[i] == OP_MUL)
				got = mul_got.pop_front();
			else
				got = div_got.pop_front();
			if (got !== {r_tab[i], q_tab[i]})
			begin
				$display("ERR %0t: row %0d a=%h b=%h gave %h rem %h, expected %h rem %h",
					$time, i, a_tab[i], b_tab[i], got[W-1:0], got[2*W-1:W], q_tab[i], r_tab[i]);
				ok = 1'b0;
			end
		end
		tally($sformatf("row %0d op %0d", i, op_tab[i]), ok);
	endtask

	initial
	begin
		int i;
		int n;
		logic ok;
		rst = 1'b1;
		mul_start = 1'b0;
		div_start = 1'b0;
		div_signed = 1'b0;
		a = '0;
		b = '0;
		load_directed();
		fill_random();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		ok = 1'b1;
		if (mul_idle !== 1'b1 || div_idle !== 1'b1 || result_valid !== 1'b0)
		begin
			$display("ERR %0t: after reset idle %b %b valid %b", $time, mul_idle, div_idle,
				result_valid);
			ok = 1'b0;
		end
		tally("reset state", ok);
		i = 0;
		while (i < NUM_ROWS)
		begin
			n = pair_tab[i] ? 2 : 1;
			wait_idle(i);
			drive_row(i);
			if (pair_tab[i])
			begin
				// partner start lag cycles later, or on the same edge
				if (lag_tab[i] > 0)
				begin
					@(negedge clk);
					mul_start = 1'b0;
					div_start = 1'b0;
					repeat (lag_tab[i] - 1) @(negedge clk);
					wait_idle(i + 1);
				end
				drive_row(i + 1);
			end
			@(negedge clk);
			mul_start = 1'b0;
			div_start = 1'b0;
			collect_results(n);
			for (int k = 0; k < n; k++)
				check_row(i + k);
			if (mul_got.size() + div_got.size() != 0)
			begin
				$display("rows from %0d gave %0d more result pulses than started", i,
					mul_got.size() + div_got.size());
				fail_cnt++;
				mul_got.delete();
				div_got.delete();
			end
			i += n;
		end
		// second start held while busy, only the first counts
		ok = 1'b1;
		a = 32'd3;
		b = 32'd5;
		mul_start = 1'b1;
		@(negedge clk);
		a = 32'd7;
		b = 32'd9;
		if (mul_idle !== 1'b0)
		begin
			$display("ERR %0t: mul_idle high right after an accepted start", $time);
			ok = 1'b0;
		end
		@(negedge clk);
		mul_start = 1'b0;
		collect_results(1);
		if (mul_got.size() != 1)
		begin
			$display("multiplier gave %0d result pulses for one accepted start", mul_got.size());
			ok = 1'b0;
		end
		else if (mul_got[0] !== expect_of(OP_MUL, 32'd3, 32'd5))
		begin
			$display("ERR %0t: multiply started while busy gave %h", $time, mul_got[0]);
			ok = 1'b0;
		end
		mul_got.delete();
		tally("start while busy", ok);
		$display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== muldiv_top.f ====
+incdir+source
+incdir+testbench
source/muldiv_pkg.sv
source/mul_unit.sv
source/div_unit.sv
source/result_arbiter.sv
source/muldiv_top.sv
testbench/tb_muldiv.sv

// ==== Bender.yml ====
package:
  name: muldiv

sources:
  - include_dirs:
      - source
    files:
      - source/muldiv_pkg.sv
      - source/mul_unit.sv
      - source/div_unit.sv
      - source/result_arbiter.sv
      - source/muldiv_top.sv
  - target: test
    include_dirs:
      - source
      - testbench
    files:
      - testbench/tb_muldiv.sv
